// ==== dv/div_unit_tb.sv ====
`timescale 1ns/1ns

module div_unit_tb;

    localparam int num_ops = 18;
    localparam int clk_period_ns = 20;
    localparam int watchdog_ns = num_ops * 40 * clk_period_ns + 4000;

    logic                          clk;
    logic                          reset;
    logic                          flush;
    logic                          req_valid;
    logic [div_pkg::xlen-1:0]      req_dividend;
    logic [div_pkg::xlen-1:0]      req_divisor;
    logic [div_pkg::tag_width-1:0] req_phys_tag;
    logic [div_pkg::tag_width-1:0] req_rs_tag;
    logic [div_pkg::xlen-1:0]      req_pc;
    logic                          req_ready;
    logic                          resp_ready;
    logic                          resp_valid;
    logic [div_pkg::xlen-1:0]      resp_quotient;
    logic [div_pkg::xlen-1:0]      resp_remainder;
    logic [div_pkg::tag_width-1:0] resp_phys_tag;
    logic [div_pkg::tag_width-1:0] resp_rs_tag;
    logic [div_pkg::xlen-1:0]      resp_pc;

    logic [31:0]       lcg_state;
    div_pkg::div_req_t sent_q[$];  // Accepted requests in order.

    tb_clock #(.period(clk_period_ns)) tb_clock_i (.clk(clk));

    div_unit_top div_unit_top_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .req_valid      (req_valid),
        .req_dividend   (req_dividend),
        .req_divisor    (req_divisor),
        .req_phys_tag   (req_phys_tag),
        .req_rs_tag     (req_rs_tag),
        .req_pc         (req_pc),
        .req_ready      (req_ready),
        .resp_ready     (resp_ready),
        .resp_valid     (resp_valid),
        .resp_quotient  (resp_quotient),
        .resp_remainder (resp_remainder),
        .resp_phys_tag  (resp_phys_tag),
        .resp_rs_tag    (resp_rs_tag),
        .resp_pc        (resp_pc)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Shifted down by a random amount so quotients vary in size.
    function automatic logic [31:0] rand_divisor();
        logic [31:0] r;
        logic [31:0] s;
        r = next_rand();
        s = next_rand();
        return r >> s[4:0];
    endfunction

    function automatic logic [31:0] expected_quotient(input logic [31:0] a, input logic [31:0] b);
        if (b == 32'd0) begin
            return 32'hffff_ffff;
        end
        return a / b;
    endfunction

    function automatic logic [31:0] expected_remainder(input logic [31:0] a, input logic [31:0] b);
        if (b == 32'd0) begin
            return a;
        end
        return a % b;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, want));
        end
    endtask

    // Call right after a rising edge; returns right after the accepting edge.
    task automatic issue_op(input logic [31:0] dividend, input logic [31:0] divisor);
        div_pkg::div_req_t r;
        logic [31:0]       t;
        r.dividend = dividend;
        r.divisor = divisor;
        t = next_rand();
        r.phys_tag = t[6:0];
        t = next_rand();
        r.rs_tag = t[6:0];
        t = next_rand();
        r.pc = {t[31:2], 2'b00};
        req_valid <= 1'b1;
        req_dividend <= r.dividend;
        req_divisor <= r.divisor;
        req_phys_tag <= r.phys_tag;
        req_rs_tag <= r.rs_tag;
        req_pc <= r.pc;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        sent_q.push_back(r);
    endtask

    task automatic check_resp();
        div_pkg::div_req_t want;
        if (sent_q.size() == 0) begin
            fail_run("A response arrived while no request was outstanding.");
        end else begin
            want = sent_q.pop_front();
            check_value("resp_quotient", resp_quotient,
                        expected_quotient(want.dividend, want.divisor));
            check_value("resp_remainder", resp_remainder,
                        expected_remainder(want.dividend, want.divisor));
            check_value("resp_phys_tag", 32'(resp_phys_tag), 32'(want.phys_tag));
            check_value("resp_rs_tag", 32'(resp_rs_tag), 32'(want.rs_tag));
            check_value("resp_pc", resp_pc, want.pc);
        end
    endtask

    task automatic collect_resps(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            while (!(resp_valid && resp_ready)) begin
                @(negedge clk);
            end
            check_resp();
            @(posedge clk);  // Bus takes it here.
        end
    endtask

    task automatic run_one(input logic [31:0] dividend, input logic [31:0] divisor);
        issue_op(dividend, divisor);
        req_valid <= 1'b0;
        collect_resps(1);
    endtask

    task automatic run_single_ops();
        resp_ready <= 1'b1;
        run_one(32'd10, 32'd3);
        run_one(32'd7, 32'd7);
        run_one(32'd0, 32'd5);
        run_one(32'hffff_ffff, 32'd1);
        run_one(next_rand(), rand_divisor());
    endtask

    task automatic run_div_by_zero();
        resp_ready <= 1'b1;
        run_one(32'h1234_5678, 32'd0);
        run_one(next_rand(), 32'd0);
    endtask

    task automatic run_latency();
        int cycles;
        resp_ready <= 1'b1;
        issue_op(next_rand(), rand_divisor());
        req_valid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!resp_valid);
        check_value("resp_valid latency", 32'(cycles), 32'd34);  // Queue 1 plus core 33.
        check_resp();
        @(posedge clk);
    endtask

    task automatic run_burst();
        int          i;
        logic [31:0] hold_q;
        logic [31:0] hold_r;
        logic [31:0] hold_phys;
        logic [31:0] hold_rs;
        logic [31:0] hold_pc;
        logic [31:0] last_a;
        logic [31:0] last_b;
        resp_ready <= 1'b0;
        for (i = 0; i < 5; i++) begin
            issue_op(next_rand(), rand_divisor());
        end
        last_a = next_rand();
        last_b = rand_divisor();
        fork
            begin
                issue_op(last_a, last_b);  // Stalls until the queue drains.
                req_valid <= 1'b0;
            end
            begin
                @(negedge clk);
                check_value("req_ready", 32'(req_ready), 32'd0);  // Queue is full.
                while (!resp_valid) begin
                    @(negedge clk);
                end
                hold_q = resp_quotient;
                hold_r = resp_remainder;
                hold_phys = 32'(resp_phys_tag);
                hold_rs = 32'(resp_rs_tag);
                hold_pc = resp_pc;
                repeat (8) begin
                    @(negedge clk);
                    check_value("resp_valid", 32'(resp_valid), 32'd1);
                    check_value("resp_quotient", resp_quotient, hold_q);
                    check_value("resp_remainder", resp_remainder, hold_r);
                    check_value("resp_phys_tag", 32'(resp_phys_tag), hold_phys);
                    check_value("resp_rs_tag", 32'(resp_rs_tag), hold_rs);
                    check_value("resp_pc", resp_pc, hold_pc);
                    check_value("req_ready", 32'(req_ready), 32'd0);
                end
                @(posedge clk);
                resp_ready <= 1'b1;
                collect_resps(6);
            end
        join
    endtask

    task automatic run_flush();
        int i;
        resp_ready <= 1'b1;
        for (i = 0; i < 3; i++) begin
            issue_op(next_rand(), rand_divisor());
        end
        req_valid <= 1'b0;
        repeat (5) @(posedge clk);
        flush <= 1'b1;  // First op is mid computation.
        @(posedge clk);
        flush <= 1'b0;
        sent_q.delete();
        for (i = 0; i < 60; i++) begin
            @(negedge clk);
            check_value("resp_valid", 32'(resp_valid), 32'd0);
        end
        @(posedge clk);
        run_one(next_rand(), rand_divisor());
    endtask

    initial begin
        #(watchdog_ns);
        fail_run("Timeout: the DUT stopped responding.");
    end

    initial begin
        lcg_state = 32'h63a3ecf4;
        reset = 1'b1;
        flush = 1'b0;
        req_valid = 1'b0;
        req_dividend = '0;
        req_divisor = '0;
        req_phys_tag = '0;
        req_rs_tag = '0;
        req_pc = '0;
        resp_ready = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        run_single_ops();
        run_div_by_zero();
        run_latency();
        run_burst();
        run_flush();
        if (sent_q.size() != 0) begin
            fail_run("Some accepted requests never produced a response.");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;  // Half period per phase.

endmodule

// ==== src.f ====
src/div_pkg.sv
src/fu_if.sv
src/div_issue_queue.sv
src/div_core.sv
src/div_unit_top.sv
dv/tb_clock.sv
dv/div_unit_tb.sv

// ==== src/div_core.sv ====
`timescale 1ns/1ns

module div_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    fu_if.consumer             issue,
    input  logic               resp_ready,
    output logic               resp_valid,
    output div_pkg::div_resp_t resp
);

    localparam int w = div_pkg::xlen;

    logic                                busy;
    logic                                ready_q;
    logic [div_pkg::iter_cnt_width-1:0]  iter_cnt;
    logic [2*w-1:0]                      rq;        // Remainder:quotient.
    logic [w-1:0]                        divisor_q;
    logic [div_pkg::tag_width-1:0]       phys_tag_q;
    logic [div_pkg::tag_width-1:0]       rs_tag_q;
    logic [w-1:0]                        pc_q;
    logic [w:0]                          part_rem;
    logic [w:0]                          diff;
    logic [2*w-1:0]                      rq_next;
    logic                                accept;
    logic                                step;
    logic                                finish;
    logic                                resp_taken;

    assign issue.ready = ready_q;

    assign accept = issue.valid && ready_q && !flush;
    assign step = busy && (iter_cnt != '0);
    assign finish = busy && (iter_cnt == '0);
    assign resp_taken = resp_valid && resp_ready;

    // Shifted partial remainder needs one extra bit.
    assign part_rem = rq[2*w-1:w-1];
    assign diff = part_rem - {1'b0, divisor_q};

    always_comb begin
        if (diff[w]) begin
            rq_next = {rq[2*w-2:0], 1'b0};  // Borrow, restore.
        end else begin
            rq_next = {diff[w-1:0], rq[w-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            iter_cnt <= '0;
            resp_valid <= 1'b0;
            ready_q <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
            iter_cnt <= '0;
            resp_valid <= 1'b0;
            ready_q <= 1'b1;
        end else begin
            if (accept) begin
                busy <= 1'b1;
                iter_cnt <= div_pkg::iter_cnt_width'(div_pkg::div_iters);
                ready_q <= 1'b0;
            end else if (step) begin
                iter_cnt <= iter_cnt - 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
                resp_valid <= 1'b1;  // Held until taken.
            end else if (resp_taken) begin
                resp_valid <= 1'b0;
                ready_q <= 1'b1;
            end else if (!busy && !resp_valid) begin
                ready_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rq <= {{w{1'b0}}, issue.payload.dividend};
            divisor_q <= issue.payload.divisor;
            phys_tag_q <= issue.payload.phys_tag;
            rs_tag_q <= issue.payload.rs_tag;
            pc_q <= issue.payload.pc;
        end else if (step) begin
            rq <= rq_next;
        end
        if (finish) begin
            resp.quotient <= rq[w-1:0];
            resp.remainder <= rq[2*w-1:w];
            resp.phys_tag <= phys_tag_q;
            resp.rs_tag <= rs_tag_q;
            resp.pc <= pc_q;
        end
    end

    // Bus back-pressure must not lose or alter a finished result.
    resp_hold_a: assert property (
        @(posedge clk) disable iff (reset || flush)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp)
    );

endmodule

// ==== src/div_issue_queue.sv ====
`timescale 1ns/1ns

module div_issue_queue (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              req_valid,
    input  div_pkg::div_req_t req,
    output logic              req_ready,
    fu_if.producer            deq
);

    div_pkg::div_req_t                  mem [div_pkg::queue_depth];
    logic [div_pkg::q_ptr_width-1:0]    wr_ptr;
    logic [div_pkg::q_ptr_width-1:0]    rd_ptr;
    logic [div_pkg::q_cnt_width-1:0]    count;
    logic                               push;
    logic                               pop;

    assign req_ready = (count != div_pkg::q_cnt_width'(div_pkg::queue_depth));

    // Head of the buffer, registered storage only.
    assign deq.valid = (count != '0);
    assign deq.payload = mem[rd_ptr];

    assign push = req_valid && req_ready && !flush;
    assign pop = deq.valid && deq.ready && !flush;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

    // An underflow would wrap the count past the depth as well.
    count_range_a: assert property (
        @(posedge clk) disable iff (reset)
        count <= div_pkg::q_cnt_width'(div_pkg::queue_depth)
    );

endmodule

// ==== src/div_pkg.sv ====
package div_pkg;

    localparam int xlen = 32;
    localparam int tag_width = 7;
    localparam int queue_depth = 4;
    localparam int div_iters = xlen;

    localparam int q_ptr_width = $clog2(queue_depth);
    localparam int q_cnt_width = $clog2(queue_depth + 1);
    localparam int iter_cnt_width = $clog2(div_iters + 1);

    // Operation handed over from issue.
    typedef struct packed {
        logic [xlen-1:0]      dividend;
        logic [xlen-1:0]      divisor;
        logic [tag_width-1:0] phys_tag;
        logic [tag_width-1:0] rs_tag;
        logic [xlen-1:0]      pc;
    } div_req_t;

    // Result as seen on the common data bus.
    typedef struct packed {
        logic [xlen-1:0]      quotient;
        logic [xlen-1:0]      remainder;
        logic [tag_width-1:0] phys_tag;
        logic [tag_width-1:0] rs_tag;
        logic [xlen-1:0]      pc;
    } div_resp_t;

endpackage

// ==== src/div_unit_top.sv ====
`timescale 1ns/1ns

module div_unit_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          req_valid,
    input  logic [div_pkg::xlen-1:0]      req_dividend,
    input  logic [div_pkg::xlen-1:0]      req_divisor,
    input  logic [div_pkg::tag_width-1:0] req_phys_tag,
    input  logic [div_pkg::tag_width-1:0] req_rs_tag,
    input  logic [div_pkg::xlen-1:0]      req_pc,
    output logic                          req_ready,
    input  logic                          resp_ready,
    output logic                          resp_valid,
    output logic [div_pkg::xlen-1:0]      resp_quotient,
    output logic [div_pkg::xlen-1:0]      resp_remainder,
    output logic [div_pkg::tag_width-1:0] resp_phys_tag,
    output logic [div_pkg::tag_width-1:0] resp_rs_tag,
    output logic [div_pkg::xlen-1:0]      resp_pc
);

    div_pkg::div_req_t  req;
    div_pkg::div_resp_t resp;

    fu_if #(.payload_t(div_pkg::div_req_t)) deq_if ();

    assign req.dividend = req_dividend;
    assign req.divisor = req_divisor;
    assign req.phys_tag = req_phys_tag;
    assign req.rs_tag = req_rs_tag;
    assign req.pc = req_pc;

    assign resp_quotient = resp.quotient;
    assign resp_remainder = resp.remainder;
    assign resp_phys_tag = resp.phys_tag;
    assign resp_rs_tag = resp.rs_tag;
    assign resp_pc = resp.pc;

    div_issue_queue div_issue_queue_i (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .deq       (deq_if.producer)
    );

    div_core div_core_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .issue      (deq_if.consumer),
        .resp_ready (resp_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

// ==== src/fu_if.sv ====
`timescale 1ns/1ns

// Valid/ready link between two stages of the functional unit.
// A beat moves on a rising edge with valid and ready both high.
// Once valid is up, it and the payload hold until the beat moves,
// unless the pipeline is flushed.
interface fu_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     ready;
    payload_t payload;

    modport producer (
        output valid,
        output payload,
        input  ready
    );

    modport consumer (
        input  valid,
        input  payload,
        output ready
    );

endinterface
